// File: list.f
spiWirePkg.sv
spiRegPkg.sv
spiByteIf.sv
spiTxRxData.sv
readWriteSPIWireData.sv
spiCtrlRegs.sv
spiMaster.sv
spiSlaveModel.sv
tbSpiMaster.sv

// File: Bender.yml
package:
  name: spi_master

sources:
  - spiWirePkg.sv
  - spiRegPkg.sv
  - spiByteIf.sv
  - spiTxRxData.sv
  - readWriteSPIWireData.sv
  - spiCtrlRegs.sv
  - spiMaster.sv
  - target: simulation
    files:
      - spiSlaveModel.sv
      - tbSpiMaster.sv

// File: tbSpiMaster.sv
`default_nettype none

module tbSpiMaster;

  // Six tests with up to three bytes each
  // A byte at clkDelay 7 spans 2 x 9 half-periods of 8 cycles
  // Factor 8 leaves room for status polling and reset
  localparam int unsigned BYTE_CYCLES    = 2 * 9 * 8;
  localparam int unsigned TIMEOUT_CYCLES = 6 * 3 * BYTE_CYCLES * 8;
  // Status reads before a wait gives up
  localparam int unsigned POLL_LIMIT     = 4 * BYTE_CYCLES;
  // Cycles allowed between two spiClk edges
  localparam int unsigned EDGE_LIMIT     = 600;

  logic                clk = 1'b0;
  logic                rst;
  spiRegPkg::regAddr_e regAddr;
  logic                regWrStb;
  spiWirePkg::byte_t   regWrData;
  logic                regRdStb;
  spiWirePkg::byte_t   regRdData;
  logic                regRdValid;
  logic                spiClk;
  logic                spiMosi;
  logic                spiCs;
  logic                spiMiso;
  spiWirePkg::byte_t   slavePreset;
  spiWirePkg::byte_t   slaveRxByte;
  int unsigned         slaveByteCount;

  int unsigned cycleCount = 0;
  int          errorCount = 0;
  int          checkCount = 0;
  int          testsRun   = 0;

  always #50 clk = ~clk;

  spiMaster u_dut (
    .clk        (clk),
    .rst        (rst),
    .regAddr    (regAddr),
    .regWrStb   (regWrStb),
    .regWrData  (regWrData),
    .regRdStb   (regRdStb),
    .regRdData  (regRdData),
    .regRdValid (regRdValid),
    .spiClk     (spiClk),
    .spiMosi    (spiMosi),
    .spiCs      (spiCs),
    .spiMiso    (spiMiso)
  );

  spiSlaveModel u_slave (
    .spiClk     (spiClk),
    .spiMosi    (spiMosi),
    .spiCs      (spiCs),
    .presetByte (slavePreset),
    .spiMiso    (spiMiso),
    .rxByte     (slaveRxByte),
    .byteCount  (slaveByteCount)
  );

  // Run limit
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d clock cycles with tests still running", cycleCount);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Checks and bus access
  ////////////////////////////////////////

  task automatic checkByte(input string name, input spiWirePkg::byte_t got,
                           input spiWirePkg::byte_t expected);
    checkCount++;
    if (got !== expected)
    begin
      errorCount++;
      $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic expected);
    checkCount++;
    if (got !== expected)
    begin
      errorCount++;
      $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, expected);
    end
  endtask

  task automatic noteFailure(input string what);
    errorCount++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // Inputs change 10 units after the rising edge
  task automatic nextCycle();
    @(posedge clk);
    #10;
  endtask

  task automatic regWrite(input spiRegPkg::regAddr_e addr, input spiWirePkg::byte_t data);
    regAddr   = addr;
    regWrData = data;
    regWrStb  = 1'b1;
    nextCycle();
    regWrStb  = 1'b0;
    // No read strobe in the write cycle
    checkBit("regRdValid", regRdValid, 1'b0);
  endtask

  // Data comes back one cycle after the strobe
  task automatic regRead(input spiRegPkg::regAddr_e addr, output spiWirePkg::byte_t data);
    regAddr  = addr;
    regRdStb = 1'b1;
    nextCycle();
    regRdStb = 1'b0;
    checkBit("regRdValid", regRdValid, 1'b1);
    data = regRdData;
  endtask

  task automatic waitStatusBit(input int unsigned bitPos, input logic level,
                               output spiWirePkg::byte_t status);
    int unsigned polls;
    polls = 0;
    regRead(spiRegPkg::REG_STATUS, status);
    while ((status[bitPos] !== level) && (polls < POLL_LIMIT))
    begin
      regRead(spiRegPkg::REG_STATUS, status);
      polls++;
    end
    if (status[bitPos] !== level)
      noteFailure($sformatf("status bit %0d never reached %b", bitPos, level));
  endtask

  task automatic waitRxRdy();
    spiWirePkg::byte_t status;
    waitStatusBit(spiRegPkg::ST_RXRDY, 1'b1, status);
  endtask

  task automatic waitSpiClkToggle(output int unsigned cycles);
    logic startLevel;
    startLevel = spiClk;
    cycles     = 0;
    do
    begin
      nextCycle();
      cycles++;
    end
    while ((spiClk === startLevel) && (cycles < EDGE_LIMIT));
    if (spiClk === startLevel)
      noteFailure("spiClk stopped toggling");
  endtask

  task automatic checkSlaveCount(input int unsigned expected);
    checkCount++;
    if (slaveByteCount != expected)
    begin
      errorCount++;
      $display("Mismatch at %0t: slaveByteCount = %0d, expected %0d", $time,
               slaveByteCount, expected);
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    spiWirePkg::wireState_e engineState;
    engineState = u_dut.u_wire.state;
    testsRun++;
    if (errorCount == errorsBefore)
      $display("%s: ok, engine in %s", name, engineState.name());
    else
      $display("%s: %0d errors, engine in %s", name, errorCount - errorsBefore,
               engineState.name());
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic verifyResetState();
    int                errorsBefore;
    spiWirePkg::byte_t data;
    spiWirePkg::byte_t expected;
    errorsBefore = errorCount;
    checkBit("spiCs", spiCs, 1'b1);
    checkBit("spiClk", spiClk, 1'b1);
    regRead(spiRegPkg::REG_CLKDELAY, data);
    checkByte("CLKDELAY", data, spiWirePkg::byte_t'(spiRegPkg::CLKDELAY_RST));
    expected    = '0;
    expected[0] = spiRegPkg::CS_RST;
    regRead(spiRegPkg::REG_CTRL, data);
    checkByte("CTRL", data, expected);
    // txEmpty needs one cycle after reset so STATUS goes last
    expected = '0;
    expected[spiRegPkg::ST_TXEMPTY] = 1'b1;
    regRead(spiRegPkg::REG_STATUS, data);
    checkByte("STATUS", data, expected);
    reportTest("reset state", errorsBefore);
  endtask

  task automatic transferOneByte();
    int                errorsBefore;
    int unsigned       countBefore;
    spiWirePkg::byte_t txByte;
    spiWirePkg::byte_t data;
    errorsBefore = errorCount;
    regWrite(spiRegPkg::REG_CTRL, 8'h00);
    checkBit("spiCs", spiCs, 1'b0);
    slavePreset = spiWirePkg::byte_t'($urandom);
    txByte      = spiWirePkg::byte_t'($urandom);
    countBefore = slaveByteCount;
    regWrite(spiRegPkg::REG_TXDATA, txByte);
    waitRxRdy();
    regRead(spiRegPkg::REG_RXDATA, data);
    checkByte("RXDATA", data, slavePreset);
    checkSlaveCount(countBefore + 1);
    checkByte("slave rxByte", slaveRxByte, txByte);
    // RXDATA read clears rxRdy
    regRead(spiRegPkg::REG_STATUS, data);
    checkBit("STATUS.rxRdy", data[spiRegPkg::ST_RXRDY], 1'b0);
    reportTest("single transfer", errorsBefore);
  endtask

  task automatic checkHalfPeriods(input spiWirePkg::byte_t delay);
    int unsigned       cycles;
    int                i;
    spiWirePkg::byte_t data;
    regWrite(spiRegPkg::REG_CLKDELAY, delay);
    regWrite(spiRegPkg::REG_TXDATA, spiWirePkg::byte_t'($urandom));
    // First edge only marks the start
    waitSpiClkToggle(cycles);
    for (i = 0; i < 6; i++)
    begin
      waitSpiClkToggle(cycles);
      checkByte($sformatf("spiClk half-period at clkDelay %0d", delay),
                spiWirePkg::byte_t'(cycles), delay + 8'd1);
    end
    waitRxRdy();
    regRead(spiRegPkg::REG_RXDATA, data);
  endtask

  task automatic measureClockRate();
    int errorsBefore;
    errorsBefore = errorCount;
    checkHalfPeriods(8'd0);
    checkHalfPeriods(8'd3);
    checkHalfPeriods(8'd7);
    regWrite(spiRegPkg::REG_CLKDELAY, spiWirePkg::byte_t'(spiRegPkg::CLKDELAY_RST));
    reportTest("clock rate", errorsBefore);
  endtask

  task automatic queueTwoBytes();
    int                errorsBefore;
    int unsigned       countBefore;
    spiWirePkg::byte_t firstByte;
    spiWirePkg::byte_t secondByte;
    spiWirePkg::byte_t status;
    spiWirePkg::byte_t data;
    errorsBefore = errorCount;
    slavePreset  = spiWirePkg::byte_t'($urandom);
    firstByte    = spiWirePkg::byte_t'($urandom);
    secondByte   = spiWirePkg::byte_t'($urandom);
    countBefore  = slaveByteCount;
    regWrite(spiRegPkg::REG_TXDATA, firstByte);
    // Engine has taken the first byte once txFull drops
    waitStatusBit(spiRegPkg::ST_TXFULL, 1'b0, status);
    regWrite(spiRegPkg::REG_TXDATA, secondByte);
    // Third byte lands on a full register and is dropped
    regWrite(spiRegPkg::REG_TXDATA, ~secondByte);
    regRead(spiRegPkg::REG_STATUS, status);
    checkBit("STATUS.txFull", status[spiRegPkg::ST_TXFULL], 1'b1);
    waitRxRdy();
    regRead(spiRegPkg::REG_RXDATA, data);
    checkByte("RXDATA first", data, slavePreset);
    waitRxRdy();
    regRead(spiRegPkg::REG_RXDATA, data);
    checkByte("RXDATA second", data, slavePreset);
    checkSlaveCount(countBefore + 2);
    checkByte("slave byte 1", u_slave.rxLog[countBefore[3:0]], firstByte);
    checkByte("slave byte 2", u_slave.rxLog[(countBefore + 1) % 16], secondByte);
    regRead(spiRegPkg::REG_STATUS, status);
    checkBit("STATUS.txFull", status[spiRegPkg::ST_TXFULL], 1'b0);
    reportTest("queued bytes", errorsBefore);
  endtask

  task automatic provokeOverrun();
    int                errorsBefore;
    spiWirePkg::byte_t firstPreset;
    spiWirePkg::byte_t status;
    spiWirePkg::byte_t data;
    errorsBefore = errorCount;
    firstPreset  = spiWirePkg::byte_t'($urandom);
    slavePreset  = firstPreset;
    regWrite(spiRegPkg::REG_TXDATA, spiWirePkg::byte_t'($urandom));
    waitRxRdy();
    // Second byte must differ so the overwrite shows
    slavePreset = spiWirePkg::byte_t'($urandom);
    if (slavePreset == firstPreset)
      slavePreset = ~firstPreset;
    regWrite(spiRegPkg::REG_TXDATA, spiWirePkg::byte_t'($urandom));
    // Engine takes the byte, then goes idle once it has been received
    waitStatusBit(spiRegPkg::ST_TXFULL, 1'b0, status);
    waitStatusBit(spiRegPkg::ST_TXEMPTY, 1'b1, status);
    checkBit("STATUS.rxRdy", status[spiRegPkg::ST_RXRDY], 1'b1);
    checkBit("STATUS.overrun", status[spiRegPkg::ST_OVERRUN], 1'b1);
    regRead(spiRegPkg::REG_RXDATA, data);
    checkByte("RXDATA", data, slavePreset);
    // Previous STATUS read has cleared the flag
    regRead(spiRegPkg::REG_STATUS, status);
    checkBit("STATUS.overrun", status[spiRegPkg::ST_OVERRUN], 1'b0);
    reportTest("overrun", errorsBefore);
  endtask

  task automatic toggleChipSelect();
    int                errorsBefore;
    int unsigned       countBefore;
    spiWirePkg::byte_t data;
    errorsBefore = errorCount;
    regWrite(spiRegPkg::REG_CTRL, 8'h01);
    checkBit("spiCs", spiCs, 1'b1);
    regRead(spiRegPkg::REG_CTRL, data);
    checkByte("CTRL", data, 8'h01);
    regWrite(spiRegPkg::REG_CTRL, 8'h00);
    checkBit("spiCs", spiCs, 1'b0);
    regWrite(spiRegPkg::REG_CTRL, 8'h01);
    checkBit("spiCs", spiCs, 1'b1);
    // Deselected slave stays silent and MISO idles high
    countBefore = slaveByteCount;
    regWrite(spiRegPkg::REG_TXDATA, spiWirePkg::byte_t'($urandom));
    waitRxRdy();
    regRead(spiRegPkg::REG_RXDATA, data);
    checkByte("RXDATA", data, 8'hFF);
    checkSlaveCount(countBefore);
    reportTest("chip select", errorsBefore);
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h4817));
    rst         = 1'b1;
    regAddr     = spiRegPkg::REG_CTRL;
    regWrStb    = 1'b0;
    regWrData   = '0;
    regRdStb    = 1'b0;
    slavePreset = '0;
    // Reset held over two rising edges
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;
    verifyResetState();
    transferOneByte();
    measureClockRate();
    queueTwoBytes();
    provokeOverrun();
    toggleChipSelect();
    $display("Tests run: %0d, checks: %0d, errors: %0d", testsRun, checkCount, errorCount);
    if (errorCount == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: spiSlaveModel.sv
`default_nettype none

// SPI slave for the testbench
// Drives MISO and samples MOSI on rising spiClk while spiCs is low
module spiSlaveModel (
  input  wire logic              spiClk,
  input  wire logic              spiMosi,
  input  wire logic              spiCs,
  input  wire spiWirePkg::byte_t presetByte,
  output logic                   spiMiso,
  output spiWirePkg::byte_t      rxByte = '0,
  output int unsigned            byteCount = 0
);

  spiWirePkg::byte_t txShift = '0;
  spiWirePkg::byte_t rxShift = '0;
  logic [2:0]        bitCnt  = '0;
  logic              misoBit = 1'b1;

  // Every received byte in arrival order
  spiWirePkg::byte_t rxLog [0:15];

  // Idle high while deselected
  assign spiMiso = (spiCs !== 1'b0) ? 1'b1 : misoBit;

  always @(posedge spiClk or posedge spiCs)
  begin : shiftEdge
    spiWirePkg::byte_t outBits;
    spiWirePkg::byte_t inBits;
    if (spiCs !== 1'b0)
      bitCnt <= '0;
    else
    begin
      // Preset is taken at the first rising edge of each byte
      outBits = (bitCnt == 3'd0) ? presetByte : txShift;
      inBits  = {rxShift[spiWirePkg::DATA_W-2:0], spiMosi};
      misoBit <= outBits[spiWirePkg::DATA_W-1];
      txShift <= {outBits[spiWirePkg::DATA_W-2:0], 1'b0};
      rxShift <= inBits;
      bitCnt  <= bitCnt + 3'd1;
      // Eighth bit closes the byte
      if (bitCnt == 3'd7)
      begin
        rxByte                 <= inBits;
        rxLog[byteCount[3:0]]  <= inBits;
        byteCount              <= byteCount + 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: spiMaster.sv
`default_nettype none

module spiMaster (
  input  wire logic                clk,
  input  wire logic                rst,
  // Host register bus
  input  wire spiRegPkg::regAddr_e regAddr,
  input  wire logic                regWrStb,
  input  wire spiWirePkg::byte_t   regWrData,
  input  wire logic                regRdStb,
  output spiWirePkg::byte_t        regRdData,
  output logic                     regRdValid,
  // SPI wires
  output logic                     spiClk,
  output logic                     spiMosi,
  output logic                     spiCs,
  input  wire logic                spiMiso
);

  spiWirePkg::byte_t clkDelay;
  spiWirePkg::byte_t statusByte;
  spiWirePkg::byte_t rxByte;
  logic              txWrStb;
  logic              rxRdStb;
  logic              statusRdStb;

  // Holding regs to wire engine
  spiByteIf byteIf ();

  ////////////////////////////////////////
  // Register decode
  ////////////////////////////////////////

  spiCtrlRegs u_ctrlRegs (
    .clk         (clk),
    .rst         (rst),
    .regAddr     (regAddr),
    .regWrStb    (regWrStb),
    .regWrData   (regWrData),
    .regRdStb    (regRdStb),
    .regRdData   (regRdData),
    .regRdValid  (regRdValid),
    .clkDelay    (clkDelay),
    .spiCs       (spiCs),
    .txWrStb     (txWrStb),
    .rxRdStb     (rxRdStb),
    .statusRdStb (statusRdStb),
    .statusIn    (statusByte),
    .rxDataIn    (rxByte)
  );

  // TX and RX holding registers with flags
  spiTxRxData u_txRxData (
    .clk         (clk),
    .rst         (rst),
    .txWrStb     (txWrStb),
    .txWrData    (regWrData),
    .rxRdStb     (rxRdStb),
    .statusRdStb (statusRdStb),
    .byteIf      (byteIf.host),
    .rxDataOut   (rxByte),
    .status      (statusByte)
  );

  ////////////////////////////////////////
  // Wire engine
  ////////////////////////////////////////

  readWriteSPIWireData u_wire (
    .clk      (clk),
    .rst      (rst),
    .clkDelay (clkDelay),
    .byteIf   (byteIf.engine),
    .spiClk   (spiClk),
    .spiMosi  (spiMosi),
    .spiMiso  (spiMiso)
  );

endmodule

`default_nettype wire

// File: spiCtrlRegs.sv
`default_nettype none

module spiCtrlRegs (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire spiRegPkg::regAddr_e regAddr,
  input  wire logic                regWrStb,
  input  wire spiWirePkg::byte_t   regWrData,
  input  wire logic                regRdStb,
  output spiWirePkg::byte_t        regRdData,
  output logic                     regRdValid,
  output spiWirePkg::byte_t        clkDelay,
  output logic                     spiCs,
  output logic                     txWrStb,
  output logic                     rxRdStb,
  output logic                     statusRdStb,
  input  wire spiWirePkg::byte_t   statusIn,
  input  wire spiWirePkg::byte_t   rxDataIn
);

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////

  // Control and clock-delay registers
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      clkDelay <= spiWirePkg::byte_t'(spiRegPkg::CLKDELAY_RST);
      spiCs    <= spiRegPkg::CS_RST;
    end
    else if (regWrStb)
    begin
      case (regAddr)
        spiRegPkg::REG_CTRL:     spiCs    <= regWrData[0];
        spiRegPkg::REG_CLKDELAY: clkDelay <= regWrData;
        default:
        begin
          clkDelay <= clkDelay;
          spiCs    <= spiCs;
        end
      endcase
    end
  end

  // Strobes to the holding registers
  // TX write lands on the same edge as the bus write
  assign txWrStb     = regWrStb && (regAddr == spiRegPkg::REG_TXDATA);
  // Read side effects take place as the data is captured below
  assign rxRdStb     = regRdStb && (regAddr == spiRegPkg::REG_RXDATA);
  assign statusRdStb = regRdStb && (regAddr == spiRegPkg::REG_STATUS);

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  spiWirePkg::byte_t rdMux;

  // TXDATA is write only and reads as zero
  always_comb
  begin
    case (regAddr)
      spiRegPkg::REG_CTRL:     rdMux = {{(spiWirePkg::DATA_W-1){1'b0}}, spiCs};
      spiRegPkg::REG_CLKDELAY: rdMux = clkDelay;
      spiRegPkg::REG_RXDATA:   rdMux = rxDataIn;
      spiRegPkg::REG_STATUS:   rdMux = statusIn;
      default:                 rdMux = '0;
    endcase
  end

  // Read data one cycle after the strobe
  always_ff @(posedge clk)
  begin
    if (regRdStb)
      regRdData <= rdMux;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      regRdValid <= 1'b0;
    else
      regRdValid <= regRdStb;
  end

endmodule

`default_nettype wire

// File: readWriteSPIWireData.sv
`default_nettype none

module readWriteSPIWireData (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire spiWirePkg::byte_t clkDelay,
  spiByteIf.engine               byteIf,
  output logic                   spiClk,
  output logic                   spiMosi,
  input  wire logic              spiMiso
);

  spiWirePkg::wireState_e state;
  spiWirePkg::wireState_e nextState;

  // Control outputs and their next values
  logic nextSpiClk;
  logic nextSpiMosi;
  logic fullClr;
  logic nextFullClr;
  logic rdySet;
  logic nextRdySet;
  logic txEmpty;
  logic nextTxEmpty;

  // Datapath
  spiWirePkg::byte_t                txShift;
  spiWirePkg::byte_t                nextTxShift;
  spiWirePkg::byte_t                rxShift;
  spiWirePkg::byte_t                nextRxShift;
  spiWirePkg::byte_t                rxByte;
  spiWirePkg::byte_t                nextRxByte;
  logic [3:0]                       bitCnt;
  logic [3:0]                       nextBitCnt;
  logic [spiWirePkg::DELAY_W-1:0]   delayCnt;
  logic [spiWirePkg::DELAY_W-1:0]   nextDelayCnt;

  ////////////////////////////////////////
  // Next state logic
  ////////////////////////////////////////

  always_comb
  begin
    // Hold everything unless a state says otherwise
    nextState    = state;
    nextSpiClk   = spiClk;
    nextSpiMosi  = spiMosi;
    nextFullClr  = fullClr;
    nextRdySet   = rdySet;
    nextTxEmpty  = txEmpty;
    nextTxShift  = txShift;
    nextRxShift  = rxShift;
    nextRxByte   = rxByte;
    nextBitCnt   = bitCnt;
    nextDelayCnt = delayCnt;
    case (state)
      // Idle until the holding register has a byte
      spiWirePkg::WT_TX_DATA:
      begin
        nextRdySet  = 1'b0;
        nextTxEmpty = 1'b1;
        if (byteIf.txDataFull)
        begin
          nextState    = spiWirePkg::CLK_HI;
          nextTxShift  = byteIf.txData;
          nextRxShift  = '0;
          nextBitCnt   = '0;
          nextDelayCnt = '0;
          nextFullClr  = 1'b1;
          nextTxEmpty  = 1'b0;
        end
      end
      // High half-period, ends on a falling edge
      spiWirePkg::CLK_HI:
      begin
        nextDelayCnt = delayCnt + (spiWirePkg::DELAY_W)'(1);
        nextFullClr  = 1'b0;
        nextRdySet   = 1'b0;
        if (delayCnt == clkDelay)
        begin
          nextState    = spiWirePkg::CLK_LO;
          nextSpiClk   = 1'b0;
          // MSB first on MOSI, MISO sampled at the same edge
          nextSpiMosi  = txShift[spiWirePkg::DATA_W-1];
          nextTxShift  = {txShift[spiWirePkg::DATA_W-2:0], 1'b0};
          nextRxShift  = {rxShift[spiWirePkg::DATA_W-2:0], spiMiso};
          nextDelayCnt = '0;
        end
      end
      // Low half-period, or end of byte once eight bits are out
      spiWirePkg::CLK_LO:
      begin
        nextDelayCnt = delayCnt + (spiWirePkg::DELAY_W)'(1);
        if ((bitCnt == 4'd8) && byteIf.txDataFull)
        begin
          // Next byte already queued, chain without an idle gap
          nextState    = spiWirePkg::CLK_HI;
          nextRdySet   = 1'b1;
          nextRxByte   = rxShift;
          nextTxShift  = byteIf.txData;
          nextBitCnt   = '0;
          nextDelayCnt = '0;
          nextFullClr  = 1'b1;
        end
        else if (bitCnt == 4'd8)
        begin
          nextState  = spiWirePkg::WT_TX_DATA;
          nextRdySet = 1'b1;
          nextRxByte = rxShift;
        end
        else if (delayCnt == clkDelay)
        begin
          nextState    = spiWirePkg::CLK_HI;
          nextSpiClk   = 1'b1;
          nextBitCnt   = bitCnt + 4'd1;
          nextDelayCnt = '0;
        end
      end
      // Start-up, one cycle then idle
      spiWirePkg::ST_RW_WIRE:
      begin
        nextState    = spiWirePkg::WT_TX_DATA;
        nextSpiClk   = 1'b1;
        nextFullClr  = 1'b0;
        nextRdySet   = 1'b0;
        nextTxEmpty  = 1'b1;
        nextBitCnt   = '0;
        nextDelayCnt = '0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  // SPI clock idles high out of reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= spiWirePkg::ST_RW_WIRE;
      spiClk  <= 1'b1;
      spiMosi <= 1'b0;
      fullClr <= 1'b0;
      rdySet  <= 1'b0;
      txEmpty <= 1'b0;
    end
    else
    begin
      state   <= nextState;
      spiClk  <= nextSpiClk;
      spiMosi <= nextSpiMosi;
      fullClr <= nextFullClr;
      rdySet  <= nextRdySet;
      txEmpty <= nextTxEmpty;
    end
  end

  // Shift registers and counters, loaded at each byte start
  always_ff @(posedge clk)
  begin
    txShift  <= nextTxShift;
    rxShift  <= nextRxShift;
    rxByte   <= nextRxByte;
    bitCnt   <= nextBitCnt;
    delayCnt <= nextDelayCnt;
  end

  assign byteIf.txDataFullClr = fullClr;
  assign byteIf.txDataEmpty   = txEmpty;
  assign byteIf.rxData        = rxByte;
  assign byteIf.rxDataRdySet  = rdySet;

endmodule

`default_nettype wire

// File: spiTxRxData.sv
`default_nettype none

module spiTxRxData (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              txWrStb,
  input  wire spiWirePkg::byte_t txWrData,
  input  wire logic              rxRdStb,
  input  wire logic              statusRdStb,
  spiByteIf.host                 byteIf,
  output spiWirePkg::byte_t      rxDataOut,
  output spiWirePkg::byte_t      status
);

  ////////////////////////////////////////
  // Transmit holding register
  ////////////////////////////////////////

  spiWirePkg::byte_t txHold;
  logic              txFull;

  // Byte only, the full flag says whether it is valid
  always_ff @(posedge clk)
  begin
    if (txWrStb && !txFull)
      txHold <= txWrData;
  end

  // Write while full is dropped, no back-pressure on the bus
  always_ff @(posedge clk)
  begin
    if (rst)
      txFull <= 1'b0;
    else if (txWrStb && !txFull)
      txFull <= 1'b1;
    else if (byteIf.txDataFullClr)
      txFull <= 1'b0;
  end

  assign byteIf.txData     = txHold;
  assign byteIf.txDataFull = txFull;

  ////////////////////////////////////////
  // Receive holding register
  ////////////////////////////////////////

  spiWirePkg::byte_t rxHold;
  logic              rxRdy;
  logic              overrun;

  // Newest byte always wins
  always_ff @(posedge clk)
  begin
    if (byteIf.rxDataRdySet)
      rxHold <= byteIf.rxData;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rxRdy   <= 1'b0;
      overrun <= 1'b0;
    end
    else
    begin
      // Arrival beats a read in the same cycle
      if (byteIf.rxDataRdySet)
        rxRdy <= 1'b1;
      else if (rxRdStb)
        rxRdy <= 1'b0;
      // Previous byte never read, so flag the loss
      if (byteIf.rxDataRdySet && rxRdy)
        overrun <= 1'b1;
      else if (statusRdStb)
        overrun <= 1'b0; // sticky until status is read
    end
  end

  assign rxDataOut = rxHold;

  // Status byte, unused bits read as zero
  always_comb
  begin
    status                         = '0;
    status[spiRegPkg::ST_TXEMPTY] = byteIf.txDataEmpty;
    status[spiRegPkg::ST_TXFULL]  = txFull;
    status[spiRegPkg::ST_RXRDY]   = rxRdy;
    status[spiRegPkg::ST_OVERRUN] = overrun;
  end

endmodule

`default_nettype wire

// File: spiByteIf.sv
`default_nettype none

////////////////////////////////////////
// Byte handshake between holding regs and wire engine
////////////////////////////////////////

interface spiByteIf;

  // Transmit side
  spiWirePkg::byte_t txData;
  logic              txDataFull;
  // One-cycle pulse from the engine once txData is taken
  logic              txDataFullClr;
  // Engine idle and waiting for a byte
  logic              txDataEmpty;

  // Receive side
  spiWirePkg::byte_t rxData;
  // One-cycle strobe, rxData valid in the same cycle
  logic              rxDataRdySet;

  // Holding register side
  modport host (
    output txData, txDataFull,
    input  txDataFullClr, txDataEmpty, rxData, rxDataRdySet
  );

  // Wire engine side
  modport engine (
    input  txData, txDataFull,
    output txDataFullClr, txDataEmpty, rxData, rxDataRdySet
  );

endinterface

`default_nettype wire

// File: spiRegPkg.sv
`default_nettype none

////////////////////////////////////////
// Host register map
////////////////////////////////////////

package spiRegPkg;

  // Register bus address width
  localparam int unsigned ADDR_W = 3;

  // Register addresses, used as the bus opcode
  typedef enum logic [ADDR_W-1:0] {
    REG_CTRL     = 3'd0,
    REG_CLKDELAY = 3'd1,
    REG_TXDATA   = 3'd2,
    REG_RXDATA   = 3'd3,
    REG_STATUS   = 3'd4
  } regAddr_e;

  // Bit positions in the status byte
  localparam int unsigned ST_TXEMPTY = 0;
  localparam int unsigned ST_TXFULL  = 1;
  localparam int unsigned ST_RXRDY   = 2;
  localparam int unsigned ST_OVERRUN = 3;

  // Control register values after reset
  localparam int unsigned CLKDELAY_RST = 4;
  // Chip select starts deselected
  localparam logic CS_RST = 1'b1;

endpackage

`default_nettype wire

// File: spiWirePkg.sv
`default_nettype none

////////////////////////////////////////
// Wire side definitions
////////////////////////////////////////

package spiWirePkg;

  // One byte on the SPI wire
  localparam int unsigned DATA_W = 8;

  // Width of the half-period setting and its counter
  localparam int unsigned DELAY_W = 8;

  typedef logic [DATA_W-1:0] byte_t;

  // Wire engine FSM
  // ST_RW_WIRE is the start-up state entered from reset
  typedef enum logic [1:0] {
    WT_TX_DATA = 2'b00,
    CLK_HI     = 2'b01,
    CLK_LO     = 2'b10,
    ST_RW_WIRE = 2'b11
  } wireState_e;

endpackage

`default_nettype wire
